// File: board_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths and limits for the board glue on the 28 MHz domain.
// Samples are 15-bit signed two's complement, as the chipset DAC words.
// Seven-segment digits are active low, segment a in bit 0.
// Switch bit 0 was the PLL reset on the board and carries no function here.
////////////////////////////////////////////////////////////////////////////

package board_pkg;

  localparam int SAMPLE_W  = 15;   // Audio sample word, signed
  localparam int VOL_W     = 7;    // Volume register width
  localparam int VOL_MAX   = 100;  // Volume saturation ceiling
  localparam int VOL_SHIFT = 7;    // Scale shift after multiply
  localparam int TRACK_W   = 8;    // Floppy track number
  localparam int SEG_W     = 7;    // One display digit
  localparam int SW_W      = 10;   // Slide switch bank
  localparam int KEY_W     = 4;    // Push key bank, active low

  ////////////////////////////////////////////////////////////////////////////
  // Switch bank, seen as a raw word or as named configuration fields
  ////////////////////////////////////////////////////////////////////////////

  typedef union packed {
    logic [SW_W-1:0] raw;          // As sampled from the pins
    struct packed {
      logic       scandbl_off;     // Bit 9, 15 kHz video
      logic       joy_emu_en;      // Bit 8, keyboard joystick
      logic       exchan;          // Bit 7, swap left and right
      logic       mix;             // Bit 6, centered mix
      logic       boot_sel;        // Bit 5, flash boot location
      logic [3:0] ctrl_cfg;        // Bits 4..1, control block config
      logic       reserved;        // Bit 0, old PLL reset
    } f;
  } sw_bank_u;

endpackage

// File: board_config.sv
////////////////////////////////////////////////////////////////////////////
// Switch and key synchronizers, configuration decode and volume register.
// Keys are active low, key[3] steps the volume up and key[2] down.
// One step per press, taken on the synchronized falling edge.
// Both keys pressed in the same cycle cancel out.
// SYNC_STAGES must be at least 1.
////////////////////////////////////////////////////////////////////////////

module board_config
  import board_pkg::*;
#(
  parameter int SYNC_STAGES = 2,   // Synchronizer depth
  parameter int VOL_INIT    = 64   // Volume after reset
) (
  input  logic             clk_28,
  input  logic             pll_locked,
  input  logic [SW_W-1:0]  sw,
  input  logic [KEY_W-1:0] key,
  output logic             exchan,
  output logic             mix,
  output logic             scandbl_off,
  output logic             joy_emu_en,
  output logic             boot_sel,
  output logic [3:0]       ctrl_cfg,
  output logic [VOL_W-1:0] volume
);

  logic [SW_W-1:0]  sw_sr  [SYNC_STAGES];  // Switch flop chain
  logic [KEY_W-1:0] key_sr [SYNC_STAGES];  // Key flop chain
  sw_bank_u         sw_cfg;                // Synchronized switch word
  logic [1:0]       key_now;               // {up, down} synchronized
  logic [1:0]       key_last;              // {up, down} one cycle back
  logic             up_pulse;
  logic             dn_pulse;

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sw_sr[i]  <= '0;                   // Switches read as off
        key_sr[i] <= '1;                   // Keys read as released
      end
    end else begin
      sw_sr[0]  <= sw;
      key_sr[0] <= key;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sw_sr[i]  <= sw_sr[i-1];
        key_sr[i] <= key_sr[i-1];
      end
    end
  end

  assign sw_cfg.raw = sw_sr[SYNC_STAGES-1];
  assign key_now    = key_sr[SYNC_STAGES-1][3:2];

  // Decoded levels, one register past the chain
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      exchan      <= 1'b0;
      mix         <= 1'b0;
      scandbl_off <= 1'b0;
      joy_emu_en  <= 1'b0;
      boot_sel    <= 1'b0;
      ctrl_cfg    <= '0;
    end else begin
      exchan      <= sw_cfg.f.exchan;
      mix         <= sw_cfg.f.mix;
      scandbl_off <= sw_cfg.f.scandbl_off;
      joy_emu_en  <= sw_cfg.f.joy_emu_en;
      boot_sel    <= sw_cfg.f.boot_sel;
      ctrl_cfg    <= sw_cfg.f.ctrl_cfg;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Press detect and saturating volume
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      key_last <= '1;
      up_pulse <= 1'b0;
      dn_pulse <= 1'b0;
    end else begin
      key_last <= key_now;
      up_pulse <= key_last[1] & ~key_now[1];  // High to low on key[3]
      dn_pulse <= key_last[0] & ~key_now[0];  // High to low on key[2]
    end
  end

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      volume <= VOL_W'(VOL_INIT);
    end else if (up_pulse && !dn_pulse && volume < VOL_MAX) begin
      volume <= volume + 1'b1;
    end else if (dn_pulse && !up_pulse && volume != '0) begin
      volume <= volume - 1'b1;
    end
  end

  a_vol_max : assert property (@(posedge clk_28) disable iff (!pll_locked)
    volume <= VOL_MAX);

  // Simultaneous presses must not move the level a cycle later
  a_vol_both : assert property (@(posedge clk_28) disable iff (!pll_locked)
    (up_pulse && dn_pulse) |=> $stable(volume));

endmodule

// File: audio_mixer.sv
////////////////////////////////////////////////////////////////////////////
// Two-stage audio path, one sample pair accepted every cycle.
// Stage 1 swaps and mixes, stage 2 scales by the volume live at that cycle.
// Shifts are arithmetic and round toward minus infinity.
// Latency is 2 cycles; no back-pressure.
////////////////////////////////////////////////////////////////////////////

module audio_mixer
  import board_pkg::*;
(
  input  logic                       clk_28,
  input  logic                       pll_locked,
  input  logic signed [SAMPLE_W-1:0] ldata,
  input  logic signed [SAMPLE_W-1:0] rdata,
  input  logic                       exchan,
  input  logic                       mix,
  input  logic        [VOL_W-1:0]    volume,
  output logic signed [SAMPLE_W-1:0] left_out,
  output logic signed [SAMPLE_W-1:0] right_out
);

  logic signed [SAMPLE_W-1:0] l_sel;   // After channel swap
  logic signed [SAMPLE_W-1:0] r_sel;
  logic signed [SAMPLE_W-1:0] l_s1;    // Stage 1 result
  logic signed [SAMPLE_W-1:0] r_s1;

  // Three quarters of own channel plus a quarter of the other
  function automatic logic signed [SAMPLE_W-1:0] mix_chan(
    input logic signed [SAMPLE_W-1:0] own,
    input logic signed [SAMPLE_W-1:0] other
  );
    return own - (own >>> 2) + (other >>> 2);  // Stays in range
  endfunction

  // Unsigned volume times signed sample, then drop VOL_SHIFT bits
  function automatic logic signed [SAMPLE_W-1:0] scale_chan(
    input logic signed [SAMPLE_W-1:0] smp,
    input logic        [VOL_W-1:0]    vol
  );
    logic signed [SAMPLE_W+VOL_W:0] prod;
    prod = smp * $signed({1'b0, vol});          // Zero-extend volume
    return prod[SAMPLE_W+VOL_SHIFT-1:VOL_SHIFT];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1, swap and mix
  ////////////////////////////////////////////////////////////////////////////

  assign l_sel = exchan ? rdata : ldata;
  assign r_sel = exchan ? ldata : rdata;

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      l_s1 <= '0;
      r_s1 <= '0;
    end else begin
      l_s1 <= mix ? mix_chan(l_sel, r_sel) : l_sel;
      r_s1 <= mix ? mix_chan(r_sel, l_sel) : r_sel;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2, volume scaling
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      left_out  <= '0;
      right_out <= '0;
    end else begin
      left_out  <= scale_chan(l_s1, volume);  // Volume of this cycle
      right_out <= scale_chan(r_s1, volume);
    end
  end

  // Unknown input or volume would show up here two cycles on
  a_out_known : assert property (@(posedge clk_28) disable iff (!pll_locked)
    !$isunknown({left_out, right_out}));

endmodule

// File: hex_display.sv
////////////////////////////////////////////////////////////////////////////
// Registered seven-segment encoder, hexadecimal font, active low.
// hex1:hex0 show the track number, hex3:hex2 show the volume.
// Latency is 1 cycle; all segments dark after reset.
////////////////////////////////////////////////////////////////////////////

module hex_display
  import board_pkg::*;
(
  input  logic               clk_28,
  input  logic               pll_locked,
  input  logic [TRACK_W-1:0] track,
  input  logic [VOL_W-1:0]   volume,
  output logic [SEG_W-1:0]   hex0,
  output logic [SEG_W-1:0]   hex1,
  output logic [SEG_W-1:0]   hex2,
  output logic [SEG_W-1:0]   hex3
);

  // Segment g in bit 6 down to a in bit 0, a zero lights it
  function automatic logic [SEG_W-1:0] seg_font(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;              // Every segment lit
      4'h9:    return 7'h10;
      4'ha:    return 7'h08;
      4'hb:    return 7'h03;              // Lower case b
      4'hc:    return 7'h46;
      4'hd:    return 7'h21;              // Lower case d
      4'he:    return 7'h06;
      default: return 7'h0e;              // F
    endcase
  endfunction

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      hex0 <= '1;                                   // Dark
      hex1 <= '1;
      hex2 <= '1;
      hex3 <= '1;
    end else begin
      hex0 <= seg_font(track[3:0]);
      hex1 <= seg_font(track[TRACK_W-1:4]);
      hex2 <= seg_font(volume[3:0]);
      hex3 <= seg_font({1'b0, volume[VOL_W-1:4]});  // Top three bits only
    end
  end

  // Volume tops out at 100, so the high digit never reaches 7.
  // The other digits may legally light all segments.
  a_hex3_range : assert property (@(posedge clk_28) disable iff (!pll_locked)
    hex3 != seg_font(4'h7));

endmodule

// File: board_top.sv
////////////////////////////////////////////////////////////////////////////
// Board glue top, all logic on clk_28 with pll_locked as async reset.
// SD data-in comes from the card while its select is low, else the host.
// Synchronizer depth and reset volume are set here.
////////////////////////////////////////////////////////////////////////////

module board_top
  import board_pkg::*;
#(
  parameter int SYNC_STAGES = 2,   // Switch and key synchronizer depth
  parameter int VOL_INIT    = 64   // Volume after reset
) (
  input  logic                       clk_28,
  input  logic                       pll_locked,
  input  logic        [SW_W-1:0]     sw,           // Slide switches
  input  logic        [KEY_W-1:0]    key,          // Push keys, active low
  input  logic signed [SAMPLE_W-1:0] ldata,        // Left DAC word
  input  logic signed [SAMPLE_W-1:0] rdata,        // Right DAC word
  input  logic        [TRACK_W-1:0]  track,        // Floppy track number
  input  logic                       sd_cs_n,      // SD card select
  input  logic                       sd_dat,       // SD card MISO
  input  logic                       host_sdo,     // Host SPI data out
  output logic                       spi_di,       // SPI data to control block
  output logic signed [SAMPLE_W-1:0] left_out,
  output logic signed [SAMPLE_W-1:0] right_out,
  output logic        [SEG_W-1:0]    hex0,
  output logic        [SEG_W-1:0]    hex1,
  output logic        [SEG_W-1:0]    hex2,
  output logic        [SEG_W-1:0]    hex3,
  output logic                       scandbl_off,  // Scan doubler disable
  output logic                       joy_emu_en,   // Joystick emulation
  output logic                       boot_sel,     // Flash boot location
  output logic        [3:0]          ctrl_cfg      // Control block config
);

  logic             exchan;        // Swap left and right
  logic             mix;           // Centered mix
  logic [VOL_W-1:0] volume;

  assign spi_di = !sd_cs_n ? sd_dat : host_sdo;  // Card or host data-in

  board_config #(
    .SYNC_STAGES (SYNC_STAGES),
    .VOL_INIT    (VOL_INIT)
  ) u_config (
    .clk_28      (clk_28),
    .pll_locked  (pll_locked),
    .sw          (sw),
    .key         (key),
    .exchan      (exchan),
    .mix         (mix),
    .scandbl_off (scandbl_off),
    .joy_emu_en  (joy_emu_en),
    .boot_sel    (boot_sel),
    .ctrl_cfg    (ctrl_cfg),
    .volume      (volume)
  );

  audio_mixer u_audio (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .ldata      (ldata),
    .rdata      (rdata),
    .exchan     (exchan),
    .mix        (mix),
    .volume     (volume),
    .left_out   (left_out),
    .right_out  (right_out)
  );

  hex_display u_hex (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .track      (track),
    .volume     (volume),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3)
  );

endmodule

// File: tb_board_ref.svh
////////////////////////////////////////////////////////////////////////////
// Reference model functions, included inside the testbench module.
// The including scope must import board_pkg for the widths and limits.
// Samples and volumes travel as int; results fit the DUT port widths.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_BOARD_REF_SVH
`define TB_BOARD_REF_SVH

// Integer division rounding toward minus infinity
function automatic int div_floor(input int num, input int den);
  int q;
  q = num / den;                                   // Truncates toward zero
  if ((num % den != 0) && ((num < 0) != (den < 0)))
    q = q - 1;                                     // Pull negatives down
  return q;
endfunction

// Three quarters of own channel plus a quarter of the other
function automatic int ref_mix(input int own, input int other);
  return own - div_floor(own, 4) + div_floor(other, 4);
endfunction

// Unsigned volume gain, floor of the product over 2**VOL_SHIFT
function automatic int ref_scale(input int smp, input int vol);
  return div_floor(smp * vol, 1 << VOL_SHIFT);
endfunction

// Common hex font written active high, segment a in bit 0
function automatic logic [SEG_W-1:0] ref_seg(input int nib);
  logic [SEG_W-1:0] lit [16];
  lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
          7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
  return ~lit[nib & 15];                           // Board digits are active low
endfunction

// One press event, saturating at 0 and VOL_MAX
function automatic int ref_vol_step(input int vol, input bit up, input bit dn);
  if (up && !dn)
    return (vol < VOL_MAX) ? vol + 1 : vol;
  if (dn && !up)
    return (vol > 0) ? vol - 1 : vol;
  return vol;                                      // Both or neither
endfunction

`endif

// File: tb_board_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the board glue top level.
// Audio, track display and SD data-in are compared at every falling edge.
// Volume is only observed through hex3 and hex2.
// Keys stay released during audio bursts so the volume is steady there.
////////////////////////////////////////////////////////////////////////////

module tb_board_top
  import board_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC_STAGES = 2;
  localparam int VOL_INIT    = 64;
  localparam int SEED        = 30177;
  localparam int N_SW        = 24;                 // Random switch words
  localparam int N_BURST     = 6;                  // Audio bursts per call
  localparam int BURST_LEN   = 40;
  localparam int N_TRACK     = 60;
  localparam int N_SPI       = 60;
  localparam int KEY_HOLD    = SYNC_STAGES + 4;    // Long enough to step
  localparam int KEY_GAP     = SYNC_STAGES + 6;    // Release and settle
  localparam int HELD_HOLD   = 40;                 // Long press, one step
  localparam int N_DOWN      = VOL_INIT + 6;       // Runs past the floor
  localparam int N_UP        = VOL_MAX + 4;        // Runs past the ceiling
  localparam int SW_CYC      = N_SW * (SYNC_STAGES + 4);
  localparam int AUD_CYC     = N_BURST * (SYNC_STAGES + BURST_LEN + 10);
  localparam int KEY_CYC     = (N_DOWN + N_UP + 1) * (KEY_HOLD + KEY_GAP + 3) + HELD_HOLD;
  localparam int TOTAL_CYC   = 16 + SW_CYC + 2 * AUD_CYC + N_TRACK + N_SPI + KEY_CYC;
  localparam int WATCHDOG_NS = (TOTAL_CYC + 100) * 10;

  logic                       clk_28 = 1'b0;
  logic                       pll_locked;
  logic        [SW_W-1:0]     sw;
  logic        [KEY_W-1:0]    key;
  logic signed [SAMPLE_W-1:0] ldata;
  logic signed [SAMPLE_W-1:0] rdata;
  logic        [TRACK_W-1:0]  track;
  logic                       sd_cs_n;
  logic                       sd_dat;
  logic                       host_sdo;
  logic                       spi_di;
  logic signed [SAMPLE_W-1:0] left_out;
  logic signed [SAMPLE_W-1:0] right_out;
  logic        [SEG_W-1:0]    hex0;
  logic        [SEG_W-1:0]    hex1;
  logic        [SEG_W-1:0]    hex2;
  logic        [SEG_W-1:0]    hex3;
  logic                       scandbl_off;
  logic                       joy_emu_en;
  logic                       boot_sel;
  logic        [3:0]          ctrl_cfg;

  int                  err_count   = 0;
  int                  aud_checked = 0;
  int                  vol_model   = VOL_INIT;  // Expected volume
  bit                  exchan_model;            // Swap level under test
  bit                  mix_model;               // Mix level under test
  bit                  aud_on;                  // Current pair is checkable
  logic [2*SAMPLE_W:0] aud_q [$];               // {valid, left, right}
  logic [2*SEG_W-1:0]  disp_exp;                // {hex1, hex0} due next
  bit                  disp_ok;

  `include "tb_board_ref.svh"

  board_top #(
    .SYNC_STAGES (SYNC_STAGES),
    .VOL_INIT    (VOL_INIT)
  ) uut (.*);

  always #5 clk_28 = ~clk_28;                   // 10 ns period

  task automatic report_mismatch(input string name, input logic signed [31:0] expv,
                                 input logic signed [31:0] actv);
    err_count++;
    $display("[FAIL] %s expected %0d actual %0d at %0t", name, expv, actv, $time);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process, pipeline model of the audio path and display
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_28) begin : compare
    int                  own_l;
    int                  own_r;
    int                  mix_l;
    int                  mix_r;
    logic [2*SAMPLE_W:0] entry;
    if (!pll_locked) begin
      aud_q.delete();                           // Pipeline flushed by reset
      disp_ok = 1'b0;
    end else begin
      own_l = exchan_model ? int'(rdata) : int'(ldata);
      own_r = exchan_model ? int'(ldata) : int'(rdata);
      mix_l = mix_model ? ref_mix(own_l, own_r) : own_l;
      mix_r = mix_model ? ref_mix(own_r, own_l) : own_r;
      aud_q.push_back({aud_on, SAMPLE_W'(ref_scale(mix_l, vol_model)),
                       SAMPLE_W'(ref_scale(mix_r, vol_model))});
      if (aud_q.size() > 2) begin               // Pair from two cycles back
        entry = aud_q.pop_front();
        if (entry[2*SAMPLE_W]) begin
          aud_checked++;
          if (left_out !== entry[2*SAMPLE_W-1:SAMPLE_W])
            report_mismatch("audio_left", $signed(entry[2*SAMPLE_W-1:SAMPLE_W]), left_out);
          if (right_out !== entry[SAMPLE_W-1:0])
            report_mismatch("audio_right", $signed(entry[SAMPLE_W-1:0]), right_out);
        end
      end
      if (disp_ok && hex1 !== disp_exp[2*SEG_W-1:SEG_W])
        report_mismatch("hex1_track", disp_exp[2*SEG_W-1:SEG_W], hex1);
      if (disp_ok && hex0 !== disp_exp[SEG_W-1:0])
        report_mismatch("hex0_track", disp_exp[SEG_W-1:0], hex0);
      disp_exp = {ref_seg(track[7:4]), ref_seg(track[3:0])};
      disp_ok  = 1'b1;
      if (spi_di !== (sd_cs_n ? host_sdo : sd_dat))  // Card owns data-in when selected
        report_mismatch("spi_di", sd_cs_n ? host_sdo : sd_dat, spi_di);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_volume(input string name);
    @(negedge clk_28);
    if (hex3 !== ref_seg((vol_model >> 4) & 7))  // High three bits only
      report_mismatch({name, "_hex3"}, ref_seg((vol_model >> 4) & 7), hex3);
    if (hex2 !== ref_seg(vol_model & 15))
      report_mismatch({name, "_hex2"}, ref_seg(vol_model & 15), hex2);
  endtask

  task automatic press_key(input int idx, input int hold);
    @(posedge clk_28);
    key <= key & ~(KEY_W'(1) << idx);           // Active low press
    repeat (hold) @(posedge clk_28);
    key <= '1;
    repeat (KEY_GAP) @(posedge clk_28);
    vol_model = ref_vol_step(vol_model, idx == 3, idx == 2);
    check_volume(idx == 3 ? "key_up" : "key_down");
  endtask

  task automatic run_switches();
    logic [SW_W-1:0] word;
    for (int n = 0; n < N_SW; n++) begin
      word = SW_W'($urandom);
      @(posedge clk_28);
      sw <= word;
      repeat (SYNC_STAGES + 2) @(posedge clk_28);
      @(negedge clk_28);
      if (scandbl_off !== word[9])
        report_mismatch("sw_scandbl_off", word[9], scandbl_off);
      if (joy_emu_en !== word[8])
        report_mismatch("sw_joy_emu_en", word[8], joy_emu_en);
      if (boot_sel !== word[5])
        report_mismatch("sw_boot_sel", word[5], boot_sel);
      if (ctrl_cfg !== word[4:1])
        report_mismatch("sw_ctrl_cfg", word[4:1], ctrl_cfg);
    end
  endtask

  task automatic run_audio();
    logic [SW_W-1:0] word;
    for (int b = 0; b < N_BURST; b++) begin
      word = SW_W'($urandom);
      @(posedge clk_28);
      sw <= word;
      exchan_model = word[7];
      mix_model    = word[6];
      repeat (SYNC_STAGES + 3) @(posedge clk_28);  // Let the levels settle
      for (int i = 0; i < BURST_LEN; i++) begin
        if (i > 0)
          @(posedge clk_28);
        ldata  <= SAMPLE_W'($urandom);
        rdata  <= SAMPLE_W'($urandom);
        aud_on = 1'b1;
      end
      @(posedge clk_28);
      aud_on = 1'b0;
      repeat (3) @(posedge clk_28);             // Drain before the next switch word
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    void'($urandom(SEED));
    pll_locked = 1'b0;
    sw         = '1;                            // Live inputs while reset releases
    key        = '1;                            // All released
    ldata      = 15'sh1555;
    rdata      = 15'sh2aaa;
    track      = '0;
    sd_cs_n    = 1'b1;
    sd_dat     = 1'b0;
    host_sdo   = 1'b0;
    repeat (2) @(posedge clk_28);
    pll_locked <= 1'b1;
    @(posedge clk_28);                          // First edge out of reset
    check_volume("reset");
    if (left_out !== '0)
      report_mismatch("reset_left_out", 0, left_out);
    if (right_out !== '0)
      report_mismatch("reset_right_out", 0, right_out);
    if ({scandbl_off, joy_emu_en, boot_sel, ctrl_cfg} !== '0)
      report_mismatch("reset_config", 0, {scandbl_off, joy_emu_en, boot_sel, ctrl_cfg});
    run_switches();
    run_audio();
    for (int n = 0; n < N_TRACK; n++) begin   // Display compared every cycle
      @(posedge clk_28);
      track <= TRACK_W'($urandom);
    end
    for (int n = 0; n < N_DOWN; n++)
      press_key(2, KEY_HOLD);
    press_key(3, HELD_HOLD);                  // Held key, one step only
    for (int n = 0; n < N_UP; n++)
      press_key(3, KEY_HOLD);
    run_audio();                              // Now at full volume
    for (int n = 0; n < N_SPI; n++) begin
      @(posedge clk_28);
      sd_cs_n  <= 1'($urandom);
      sd_dat   <= 1'($urandom);
      host_sdo <= 1'($urandom);
    end
    repeat (4) @(posedge clk_28);
    @(negedge clk_28);
    $display("Audio pairs checked: %0d, errors: %0d", aud_checked, err_count);
    if (err_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYC + 100);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+.
board_pkg.sv
board_config.sv
audio_mixer.sv
hex_display.sv
board_top.sv
tb_board_top.sv

// File: Bender.yml
package:
  name: board_glue

export_include_dirs:
  - .

sources:
  - board_pkg.sv
  - board_config.sv
  - audio_mixer.sv
  - hex_display.sv
  - board_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_board_top.sv
